/* tests/uart_patterns.txt */
// op_lcr_data_mask, one hex word per test, mask is the expected LSR error bits
// op: 00 regs, 01 tx, 02 rx, 03 rx_bad_parity, 04 rx_bad_stop, 05 overrun, 06 loopback
00_1b_5a_00
01_03_a5_00
01_02_3c_00
01_01_2b_00
01_00_15_00
01_1b_c3_00
01_0b_c3_00
01_3b_96_00
01_2b_96_00
01_07_81_00
01_04_0e_00
01_0f_4d_00
02_03_c9_00
02_1a_55_00
02_09_2a_00
03_1b_a7_04
03_0b_a7_04
04_03_96_08
05_03_69_02
06_03_e7_00
06_1b_71_00

/* files.f */
source/uart_pkg.sv
source/uart_regs.sv
source/uart_baud_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
tests/uart_checker.sv
tests/uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uart_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vuart_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1

/* tests/uart_tb.sv */
// UART testbench
// Plays back the pattern file over APB and the serial pins,
// predicts frames and status from the LCR rules

`timescale 1ns/1ps

module uart_tb;
  import uart_pkg::*;

  localparam int DIV          = 2;
  localparam int BIT_CYCLES   = 16 * DIV;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_PATTERNS = 32;

  logic        clk;
  logic        reset_n;
  apb_req_t    req;
  logic [7:0]  prdata;
  logic        sin;
  logic        sout;
  logic        baudout;
  logic        intr;
  logic [31:0] patterns [0:MAX_PATTERNS-1];
  int          errors;
  int          n_tests;
  int          n_failed;
  int          cycles;
  int          cycle_limit;

  uart_top uut (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .prdata  (prdata),
    .sin     (sin),
    .sout    (sout),
    .baudout (baudout),
    .intr    (intr)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if ((cycle_limit > 0) && (cycles > cycle_limit))
    begin
      $display("Timeout: run went past %0d clock cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Setup cycle then access cycle, called 2 ns after an edge
  task automatic apb_write(input logic [2:0] addr, input logic [7:0] data);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = 1'b1;
    req.paddr   = addr;
    req.pwdata  = data;
    wait_cycles(1);
    req.penable = 1'b1;
    wait_cycles(1);
    req.psel    = 1'b0;
    req.penable = 1'b0;
    req.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [2:0] addr, output logic [7:0] data);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = 1'b0;
    req.paddr   = addr;
    wait_cycles(1);
    req.penable = 1'b1;
    @(negedge clk);
    data = prdata;              // Mid access cycle
    wait_cycles(1);
    req.psel    = 1'b0;
    req.penable = 1'b0;
  endtask

  // Counts 16x enables over one bit time
  task automatic count_baud_ticks(output int ticks);
    int n;
    ticks = 0;
    for (n = 0; n < BIT_CYCLES; n++)
    begin
      if (baudout)
        ticks++;
      wait_cycles(1);
    end
  endtask

  function automatic int word_bits(input logic [7:0] lcr);
    return 5 + int'(lcr[1:0]);
  endfunction

  function automatic logic [7:0] data_mask(input logic [7:0] lcr);
    return 8'((9'h001 << word_bits(lcr)) - 9'h001);
  endfunction

  // Stick parity sends the inverse of the even select bit
  function automatic logic parity_bit(input logic [7:0] lcr, input logic [7:0] data);
    logic p;
    if (lcr[5])
      return !lcr[4];
    p = ^(data & data_mask(lcr));
    return lcr[4] ? p : !p;
  endfunction

  function automatic string op_name(input logic [7:0] op);
    case (op)
      8'h00:   return "regs";
      8'h01:   return "tx";
      8'h02:   return "rx";
      8'h03:   return "rx_bad_parity";
      8'h04:   return "rx_bad_stop";
      8'h05:   return "overrun";
      default: return "loopback";
    endcase
  endfunction

  task automatic drive_bit(input logic v);
    sin = v;
    wait_cycles(BIT_CYCLES);
  endtask

  task automatic drive_frame(input logic [7:0] lcr, input logic [7:0] data,
                             input logic bad_parity, input logic bad_stop);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < word_bits(lcr); i++)
      drive_bit(data[i]);
    if (lcr[3])
      drive_bit(parity_bit(lcr, data) ^ bad_parity);
    drive_bit(!bad_stop);
    if (lcr[2])
      drive_bit(1'b1);
    sin = 1'b1;                 // Line back to mark
  endtask

  // Samples sout at mid-bit, timed from the falling start edge
  task automatic capture_frame(input logic [7:0] lcr, output logic [7:0] data,
                               output logic par, output logic stop, output logic seen);
    int i;
    int n;
    data = 8'h00;
    par  = 1'b0;
    stop = 1'b0;
    seen = 1'b0;
    n    = 0;
    while (sout && (n < 4 * BIT_CYCLES))
    begin
      @(negedge clk);
      n++;
    end
    if (sout)
      return;
    repeat (BIT_CYCLES / 2 - 1) @(negedge clk);
    seen = !sout;
    for (i = 0; i < word_bits(lcr); i++)
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      data[i] = sout;
    end
    if (lcr[3])
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      par = sout;
    end
    repeat (BIT_CYCLES) @(negedge clk);
    stop = sout;
    wait_cycles(1);
  endtask

  task automatic wait_intr(output logic ok);
    int n;
    n = 0;
    while (!intr && (n < 24 * BIT_CYCLES))
    begin
      wait_cycles(1);
      n++;
    end
    ok = intr;
    if (!ok)
    begin
      errors++;
      $display("No interrupt came within %0d cycles", n);
    end
  endtask

  task automatic wait_temt();
    logic [7:0] v;
    int n;
    n = 0;
    apb_read(LSR, v);
    while (!v[6] && (n < 12 * BIT_CYCLES))
    begin
      apb_read(LSR, v);
      n++;
    end
    check_value("LSR TEMT", {7'b0, v[6]}, 8'h01);
  endtask

  // Idle long enough for a stray frame to end, then clear status
  task automatic settle_line();
    logic [7:0] v;
    wait_cycles(14 * BIT_CYCLES);
    apb_read(LSR, v);
    apb_read(RBR_THR_DLL, v);
  endtask

  task automatic run_regs(input logic [7:0] lcr, input logic [7:0] data);
    logic [7:0] v;
    apb_write(SCR, data);
    apb_read(SCR, v);
    check_value("SCR", v, data);
    apb_write(LCR, lcr);
    apb_read(LCR, v);
    check_value("LCR", v, lcr);
    apb_write(IER_DLM, 8'hff);
    apb_read(IER_DLM, v);
    check_value("IER", v, 8'h0f);
    apb_write(LCR, lcr | 8'h80);
    apb_read(RBR_THR_DLL, v);
    check_value("DLL", v, 8'(DIV));
    apb_read(IER_DLM, v);
    check_value("DLM", v, 8'h00);
    apb_write(LCR, lcr);
    apb_read(IER_DLM, v);
    check_value("IER", v, 8'h0f);
    apb_write(IER_DLM, 8'h02);      // THR empty source only
    apb_read(IIR, v);
    check_value("IIR", v, 8'h02);
    check_value("intr", {7'b0, intr}, 8'h01);
    apb_write(IER_DLM, 8'h00);
    check_value("intr", {7'b0, intr}, 8'h00);
  endtask

  task automatic run_tx(input logic [7:0] lcr, input logic [7:0] data);
    logic [7:0] got;
    logic [7:0] v;
    logic       par;
    logic       stop;
    logic       seen;
    apb_write(LCR, lcr);
    apb_write(RBR_THR_DLL, data);
    capture_frame(lcr, got, par, stop, seen);
    check_value("sout start bit", {7'b0, seen}, 8'h01);
    check_value("sout data", got, data & data_mask(lcr));
    if (lcr[3])
      check_value("sout parity", {7'b0, par}, {7'b0, parity_bit(lcr, data)});
    check_value("sout stop bit", {7'b0, stop}, 8'h01);
    apb_read(LSR, v);
    check_value("LSR THRE", {7'b0, v[5]}, 8'h01);
    wait_temt();
  endtask

  task automatic run_rx(input logic [7:0] op, input logic [7:0] lcr,
                        input logic [7:0] data, input logic [7:0] mask);
    logic [7:0] v;
    logic       ok;
    apb_write(LCR, lcr);
    apb_write(IER_DLM, (mask != 8'h00) ? 8'h05 : 8'h01);
    drive_frame(lcr, data, op == 8'h03, op == 8'h04);
    wait_intr(ok);
    apb_read(IIR, v);
    check_value("IIR", v, (mask != 8'h00) ? 8'h06 : 8'h04);
    apb_read(LSR, v);
    check_value("LSR errors", v & 8'h1e, mask);
    check_value("LSR DR", {7'b0, v[0]}, 8'h01);
    apb_read(RBR_THR_DLL, v);
    check_value("RBR", v, data & data_mask(lcr));
    apb_read(LSR, v);
    check_value("LSR after reads", v & 8'h1f, 8'h00);
    apb_write(IER_DLM, 8'h00);
    if (op == 8'h04)
      settle_line();
  endtask

  task automatic run_overrun(input logic [7:0] lcr, input logic [7:0] data,
                             input logic [7:0] mask);
    logic [7:0] v;
    logic       ok;
    apb_write(LCR, lcr);
    apb_write(IER_DLM, 8'h01);
    drive_frame(lcr, data, 1'b0, 1'b0);
    wait_intr(ok);
    apb_write(IER_DLM, 8'h04);      // Line status only
    drive_frame(lcr, ~data, 1'b0, 1'b0);
    wait_intr(ok);
    apb_read(IIR, v);
    check_value("IIR", v, 8'h06);
    apb_read(LSR, v);
    check_value("LSR errors", v & 8'h1e, mask);
    apb_read(RBR_THR_DLL, v);
    check_value("RBR", v, ~data & data_mask(lcr));
    sin = 1'b0;                     // Break, 13 bit times low
    wait_cycles(13 * BIT_CYCLES);
    sin = 1'b1;
    wait_intr(ok);
    apb_read(LSR, v);
    check_value("LSR BI", v & 8'h10, 8'h10);
    apb_write(IER_DLM, 8'h00);
    settle_line();
  endtask

  task automatic run_loopback(input logic [7:0] lcr, input logic [7:0] data);
    logic [7:0] v;
    logic       low_seen;
    int         n;
    apb_write(LCR, lcr);
    apb_write(MCR, 8'h10);
    apb_write(IER_DLM, 8'h01);
    apb_write(RBR_THR_DLL, data);
    low_seen = 1'b0;
    n = 0;
    while (!intr && (n < 24 * BIT_CYCLES))
    begin
      if (!sout)
        low_seen = 1'b1;
      wait_cycles(1);
      n++;
    end
    check_value("sout low in loopback", {7'b0, low_seen}, 8'h00);
    check_value("intr", {7'b0, intr}, 8'h01);
    apb_read(LSR, v);
    check_value("LSR DR", {7'b0, v[0]}, 8'h01);
    apb_read(RBR_THR_DLL, v);
    check_value("RBR", v, data & data_mask(lcr));
    wait_temt();
    apb_write(MCR, 8'h00);
    apb_write(IER_DLM, 8'h00);
  endtask

  initial
  begin
    int         i;
    int         n_pat;
    int         errs_before;
    int         ticks;
    logic [7:0] v;
    logic [7:0] op;
    clk         = 1'b0;
    reset_n     = 1'b0;
    req         = '0;
    sin         = 1'b1;
    errors      = 0;
    n_tests     = 0;
    n_failed    = 0;
    cycles      = 0;
    cycle_limit = 0;
    for (i = 0; i < MAX_PATTERNS; i++)
      patterns[i] = 32'hffffffff;
    $readmemh("tests/uart_patterns.txt", patterns);
    n_pat = 0;
    while ((n_pat < MAX_PATTERNS) && (patterns[n_pat][31:24] != 8'hff))
      n_pat++;
    cycle_limit = RESET_CYCLES + n_pat * 3 * 12 * BIT_CYCLES;
    wait_cycles(RESET_CYCLES);
    check_value("baudout in reset", {7'b0, baudout}, 8'h00);
    check_value("sout in reset", {7'b0, sout}, 8'h01);
    check_value("intr in reset", {7'b0, intr}, 8'h00);
    reset_n = 1'b1;
    wait_cycles(1);
    apb_read(LSR, v);
    check_value("LSR after reset", v, 8'h60);
    apb_write(LCR, 8'h80);
    apb_write(RBR_THR_DLL, 8'(DIV));
    apb_write(IER_DLM, 8'h00);
    apb_write(LCR, 8'h03);
    count_baud_ticks(ticks);
    check_value("baudout ticks per bit", 8'(ticks), 8'd16);
    for (i = 0; i < n_pat; i++)
    begin
      errs_before = errors;
      op = patterns[i][31:24];
      case (op)
        8'h00:   run_regs(patterns[i][23:16], patterns[i][15:8]);
        8'h01:   run_tx(patterns[i][23:16], patterns[i][15:8]);
        8'h05:   run_overrun(patterns[i][23:16], patterns[i][15:8], patterns[i][7:0]);
        8'h06:   run_loopback(patterns[i][23:16], patterns[i][15:8]);
        default: run_rx(op, patterns[i][23:16], patterns[i][15:8], patterns[i][7:0]);
      endcase
      n_tests++;
      if (errors == errs_before)
        $display("Test %0d %s passed", i, op_name(op));
      else
      begin
        n_failed++;
        $display("Test %0d %s failed", i, op_name(op));
      end
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", n_tests, n_failed, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* tests/uart_checker.sv */
// UART controller checker
// Concurrent assertions on the register and interrupt controller

`timescale 1ns/1ps

module uart_checker (
  input logic                clk,
  input logic                reset_n,
  input logic                intr,
  input uart_pkg::irq_id_e   iir_id,
  input logic [3:0]          ier,
  input logic [7:0]          lsr,
  input logic                loopback,
  input logic                sout,
  input logic                div_load,
  input logic                dlab,
  input logic                thr_take,
  input logic                thr_full
);
  import uart_pkg::*;

  logic src_pending;

  // Any enabled source, taken from the LSR as software sees it
  assign src_pending = (ier[2] && (lsr[4:1] != 4'h0)) || (ier[0] && lsr[0]) ||
                       (ier[1] && lsr[5]);

  intr_follows_iir: assert property (@(posedge clk) disable iff (!reset_n)
    (intr == src_pending) && ((iir_id != IRQ_NONE) == src_pending))
    else $error("intr or IIR code does not match the pending sources");

  // Line parked at mark while looped back
  sout_high_in_loopback: assert property (@(posedge clk) disable iff (!reset_n)
    loopback |-> sout)
    else $error("sout low during loopback");

  div_load_needs_dlab: assert property (@(posedge clk) disable iff (!reset_n)
    div_load |-> $past(dlab))
    else $error("divisor load without DLAB");

  take_needs_full: assert property (@(posedge clk) disable iff (!reset_n)
    thr_take |-> thr_full)
    else $error("THR taken while empty");

endmodule

bind uart_regs uart_checker u_checker (
  .clk      (clk),
  .reset_n  (reset_n),
  .intr     (intr),
  .iir_id   (iir_id),
  .ier      (ier),
  .lsr      (lsr),
  .loopback (loopback),
  .sout     (sout),
  .div_load (div_load),
  .dlab     (dlab),
  .thr_take (thr_take),
  .thr_full (thr_full)
);

/* source/uart_top.sv */
// UART top level
// 16450-style UART on APB, register controller with baud,
// receive and transmit datapaths

`timescale 1ns/1ps

module uart_top (
  input  logic                        clk,
  input  logic                        reset_n,
  input  uart_pkg::apb_req_t          req,
  output logic [uart_pkg::DATA_W-1:0] prdata,
  input  logic                        sin,
  output logic                        sout,
  output logic                        baudout,
  output logic                        intr
);
  import uart_pkg::*;

  line_cfg_t         line_cfg;
  rx_event_t         rx_event;
  logic [DIV_W-1:0]  divisor;
  logic              div_load;
  logic [DATA_W-1:0] thr_data;
  logic              thr_full;
  logic              thr_take;
  logic              tx_idle;
  logic              txd;
  logic              rxd_sel;

  uart_regs u_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (req),
    .prdata   (prdata),
    .line_cfg (line_cfg),
    .divisor  (divisor),
    .div_load (div_load),
    .thr_data (thr_data),
    .thr_full (thr_full),
    .thr_take (thr_take),
    .tx_idle  (tx_idle),
    .rx_event (rx_event),
    .txd      (txd),
    .sin      (sin),
    .rxd_sel  (rxd_sel),
    .sout     (sout),
    .intr     (intr)
  );

  // baudout doubles as the 16x enable for both datapaths
  uart_baud_gen u_baud_gen (
    .clk       (clk),
    .reset_n   (reset_n),
    .divisor   (divisor),
    .div_load  (div_load),
    .baud_tick (baudout)
  );

  uart_rx u_rx (
    .clk       (clk),
    .reset_n   (reset_n),
    .baud_tick (baudout),
    .rxd       (rxd_sel),
    .line_cfg  (line_cfg),
    .rx_event  (rx_event)
  );

  uart_tx u_tx (
    .clk       (clk),
    .reset_n   (reset_n),
    .baud_tick (baudout),
    .line_cfg  (line_cfg),
    .thr_data  (thr_data),
    .thr_full  (thr_full),
    .thr_take  (thr_take),
    .tx_idle   (tx_idle),
    .txd       (txd)
  );

endmodule

/* source/uart_tx.sv */
// UART transmitter
// Bit timing from the 16x enable, frame FSM for start, data,
// parity and stop bits, with the THR handshake

`timescale 1ns/1ps

module uart_tx (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        baud_tick,
  input  uart_pkg::line_cfg_t         line_cfg,
  input  logic [uart_pkg::DATA_W-1:0] thr_data,
  input  logic                        thr_full,
  output logic                        thr_take,
  output logic                        tx_idle,
  output logic                        txd
);
  import uart_pkg::*;

  tx_state_e         state;
  logic [4:0]        tick_cnt;
  logic [4:0]        tick_last;
  logic              bit_tick;
  logic [2:0]        bit_cnt;
  logic [2:0]        last_bit;
  logic [DATA_W-1:0] shift;
  logic              parity_acc;
  logic              start_frame;
  logic              shift_out;

  assign last_bit = {1'b1, line_cfg.word_len};

  // Stop bit stretch, 1.5 bits for 5-bit words
  always_comb
  begin
    if ((state == TX_STOP) && line_cfg.two_stop)
      tick_last = (line_cfg.word_len == WL5) ? 5'd23 : 5'd31;
    else
      tick_last = 5'd15;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tick_cnt <= '0;
      bit_tick <= 1'b0;
    end
    else
    begin
      bit_tick <= 1'b0;
      if (baud_tick)
      begin
        if (tick_cnt >= tick_last)
        begin
          tick_cnt <= '0;
          bit_tick <= 1'b1;
        end
        else
          tick_cnt <= tick_cnt + 5'd1;
      end
    end
  end

  // Back-to-back frames start straight from the stop bit
  assign start_frame = bit_tick && thr_full && ((state == TX_IDLE) || (state == TX_STOP));
  assign shift_out   = bit_tick && ((state == TX_START) ||
                                    ((state == TX_DATA) && (bit_cnt != last_bit)));
  assign thr_take    = start_frame;
  assign tx_idle     = (state == TX_IDLE) && !thr_full;

  always_ff @(posedge clk)
  begin
    if (start_frame)
      shift <= thr_data;
    else if (shift_out)
      shift <= shift >> 1;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state      <= TX_IDLE;
      txd        <= 1'b1;
      bit_cnt    <= '0;
      parity_acc <= 1'b0;
    end
    else if (start_frame)
    begin
      state      <= TX_START;
      txd        <= 1'b0;
      parity_acc <= !line_cfg.even_parity;
    end
    else if (bit_tick)
    begin
      case (state)
        TX_START:
        begin
          state      <= TX_DATA;
          bit_cnt    <= '0;
          txd        <= shift[0];
          parity_acc <= parity_acc ^ shift[0];
        end
        TX_DATA:
          if (bit_cnt == last_bit)
          begin
            if (line_cfg.parity_en)
            begin
              state <= TX_PARITY;
              txd   <= line_cfg.stick_parity ? !line_cfg.even_parity : parity_acc;
            end
            else
            begin
              state <= TX_STOP;
              txd   <= 1'b1;
            end
          end
          else
          begin
            bit_cnt    <= bit_cnt + 3'd1;
            txd        <= shift[0];
            parity_acc <= parity_acc ^ shift[0];
          end
        TX_PARITY:
        begin
          state <= TX_STOP;
          txd   <= 1'b1;
        end
        TX_STOP: state <= TX_IDLE;
        default: txd <= 1'b1;            // Idle, line at mark
      endcase
    end
  end

endmodule

/* source/uart_rx.sv */
// UART receiver
// Two-sample input filter, 16x oversampled receive FSM,
// parity and framing checks and break detection

`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                baud_tick,
  input  logic                rxd,
  input  uart_pkg::line_cfg_t line_cfg,
  output uart_pkg::rx_event_t rx_event
);
  import uart_pkg::*;

  logic [1:0]        samples;
  logic              rxd_filt;
  rx_state_e         state;
  logic [3:0]        phase;
  logic [2:0]        bit_cnt;
  logic [2:0]        last_bit;
  logic [DATA_W-1:0] shift;
  logic              parity_acc;
  logic              parity_bad;
  logic [3:0]        brk_cnt;
  logic              bit_sample;
  logic              data_sample;
  logic              stop_sample;
  logic [DATA_W-1:0] data_q;
  logic              done_q;
  logic              parity_err_q;
  logic              frame_err_q;
  logic              break_q;

  assign last_bit    = {1'b1, line_cfg.word_len};   // 4 + word_len
  assign data_sample = baud_tick && (state == RX_DATA) && (phase == 4'd15);
  assign stop_sample = baud_tick && (state == RX_STOP) && (phase == 4'd15);
  assign bit_sample  = baud_tick && ((state == RX_START) ? (phase == 4'd7) :
                                     ((state != RX_IDLE) && (phase == 4'd15)));

  // Line level changes only after two equal samples
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      samples  <= 2'b11;
      rxd_filt <= 1'b1;
    end
    else
    begin
      if (baud_tick)
        samples <= {samples[0], rxd};
      if (samples == 2'b00)
        rxd_filt <= 1'b0;
      else if (samples == 2'b11)
        rxd_filt <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state      <= RX_IDLE;
      phase      <= '0;
      bit_cnt    <= '0;
      parity_acc <= 1'b0;
      parity_bad <= 1'b0;
    end
    else if (baud_tick)
    begin
      phase <= phase + 4'd1;
      case (state)
        RX_IDLE:
        begin
          phase <= '0;
          if (!rxd_filt)
            state <= RX_START;
        end
        RX_START:
          if (rxd_filt)
            state <= RX_IDLE;              // Glitch, no start bit
          else if (phase == 4'd7)
          begin
            state      <= RX_DATA;         // Mid start bit, realign phase
            phase      <= '0;
            bit_cnt    <= '0;
            parity_acc <= !line_cfg.even_parity;
            parity_bad <= 1'b0;
          end
        RX_DATA:
          if (phase == 4'd15)
          begin
            parity_acc <= parity_acc ^ rxd_filt;
            bit_cnt    <= bit_cnt + 3'd1;
            if (bit_cnt == last_bit)
              state <= line_cfg.parity_en ? RX_PARITY : RX_STOP;
          end
        RX_PARITY:
          if (phase == 4'd15)
          begin
            if (line_cfg.stick_parity)
              parity_bad <= (rxd_filt == line_cfg.even_parity);
            else
              parity_bad <= (rxd_filt != parity_acc);
            state <= RX_STOP;
          end
        RX_STOP:
          if (phase == 4'd15)
            state <= RX_IDLE;              // Only the first stop bit is checked
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (data_sample)
      shift <= {rxd_filt, shift[DATA_W-1:1]};   // LSB first
    if (stop_sample)
      data_q <= shift >> (2'd3 - line_cfg.word_len);
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      done_q       <= 1'b0;
      parity_err_q <= 1'b0;
      frame_err_q  <= 1'b0;
      break_q      <= 1'b0;
      brk_cnt      <= '0;
    end
    else
    begin
      done_q  <= stop_sample;
      break_q <= 1'b0;
      if (stop_sample)
      begin
        parity_err_q <= parity_bad;
        frame_err_q  <= !rxd_filt;
      end
      // Break counts consecutive low bit samples across frames
      if (bit_sample)
      begin
        if (rxd_filt)
          brk_cnt <= '0;
        else
        begin
          if (brk_cnt != 4'hf)
            brk_cnt <= brk_cnt + 4'd1;
          if (brk_cnt == 4'd11)
            break_q <= 1'b1;               // Twelfth low sample
        end
      end
    end
  end

  assign rx_event = '{data: data_q, done: done_q, parity_err: parity_err_q,
                      frame_err: frame_err_q, break_det: break_q};

endmodule

/* source/uart_baud_gen.sv */
// UART baud generator
// Divides the system clock by the divisor latch into a 16x baud enable

`timescale 1ns/1ps

module uart_baud_gen (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [uart_pkg::DIV_W-1:0] divisor,
  input  logic                       div_load,
  output logic                       baud_tick
);
  import uart_pkg::*;

  logic [DIV_W-1:0] count;
  logic             reload;

  // Reload at one, so 0 and 1 both tick every cycle
  assign reload = (count[DIV_W-1:1] == '0) || div_load;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      count     <= '0;
      baud_tick <= 1'b0;
    end
    else if (reload)
    begin
      count     <= divisor;
      baud_tick <= 1'b1;
    end
    else
    begin
      count     <= count - 1'b1;
      baud_tick <= 1'b0;
    end
  end

endmodule

/* source/uart_regs.sv */
// UART register file and interrupt controller
// APB decode of the 16450 register map, line status flags,
// prioritized interrupt identification and loopback routing

`timescale 1ns/1ps

module uart_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  uart_pkg::apb_req_t          req,
  output logic [uart_pkg::DATA_W-1:0] prdata,
  output uart_pkg::line_cfg_t         line_cfg,
  output logic [uart_pkg::DIV_W-1:0]  divisor,
  output logic                        div_load,
  output logic [uart_pkg::DATA_W-1:0] thr_data,
  output logic                        thr_full,
  input  logic                        thr_take,
  input  logic                        tx_idle,
  input  uart_pkg::rx_event_t         rx_event,
  input  logic                        txd,
  input  logic                        sin,
  output logic                        rxd_sel,
  output logic                        sout,
  output logic                        intr
);
  import uart_pkg::*;

  logic [3:0]        ier;
  logic [7:0]        lcr;
  logic [4:0]        mcr;
  logic [DATA_W-1:0] scr;
  logic [DATA_W-1:0] dll;
  logic [DATA_W-1:0] dlm;
  logic [DATA_W-1:0] rbr;
  logic [DATA_W-1:0] lsr;
  logic              dr;
  logic              oe;
  logic              pe;
  logic              fe;
  logic              bi;
  logic              dlab;
  logic              loopback;
  logic              wr_en;
  logic              rd_en;
  logic              rbr_read;
  logic              lsr_read;
  logic              thr_write;
  logic              div_write;
  logic              line_tx;
  reg_addr_e         addr;
  irq_id_e           iir_id;

  assign addr      = reg_addr_e'(req.paddr);
  assign wr_en     = req.psel && req.penable && req.pwrite;   // Access phase only
  assign rd_en     = req.psel && req.penable && !req.pwrite;
  assign dlab      = lcr[7];
  assign loopback  = mcr[4];
  assign rbr_read  = rd_en && (addr == RBR_THR_DLL) && !dlab;
  assign lsr_read  = rd_en && (addr == LSR);
  assign thr_write = wr_en && (addr == RBR_THR_DLL) && !dlab;
  assign div_write = wr_en && dlab && ((addr == RBR_THR_DLL) || (addr == IER_DLM));

  assign line_cfg = line_cfg_t'(lcr[6:0]);
  assign divisor  = {dlm, dll};
  assign lsr      = {1'b0, tx_idle, !thr_full, bi, fe, pe, oe, dr};

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ier      <= '0;
      lcr      <= '0;
      mcr      <= '0;
      dll      <= '0;
      dlm      <= '0;
      div_load <= 1'b0;
      thr_full <= 1'b0;
    end
    else
    begin
      div_load <= div_write;   // One cycle late so the counter sees the new latch
      if (wr_en)
      begin
        case (addr)
          RBR_THR_DLL:
            if (dlab)
              dll <= req.pwdata;
          IER_DLM:
            if (dlab)
              dlm <= req.pwdata;
            else
              ier <= req.pwdata[3:0];
          LCR:     lcr <= req.pwdata;
          MCR:     mcr <= req.pwdata[4:0];
          default: ;
        endcase
      end
      if (thr_write)
        thr_full <= 1'b1;      // New byte wins over a take in the same cycle
      else if (thr_take)
        thr_full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && (addr == SCR))
      scr <= req.pwdata;
    if (thr_write)
      thr_data <= req.pwdata;
    if (rx_event.done)
      rbr <= rx_event.data;
  end

  // Sticky line status, setting has priority over the read clear
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      dr <= 1'b0;
      oe <= 1'b0;
      pe <= 1'b0;
      fe <= 1'b0;
      bi <= 1'b0;
    end
    else
    begin
      if (rx_event.done)
        dr <= 1'b1;
      else if (rbr_read)
        dr <= 1'b0;
      if (rx_event.done && dr && !rbr_read)
        oe <= 1'b1;            // Previous character never read
      else if (lsr_read)
        oe <= 1'b0;
      if (rx_event.done && rx_event.parity_err)
        pe <= 1'b1;
      else if (lsr_read)
        pe <= 1'b0;
      if (rx_event.done && rx_event.frame_err)
        fe <= 1'b1;
      else if (lsr_read)
        fe <= 1'b0;
      if (rx_event.break_det)
        bi <= 1'b1;
      else if (lsr_read)
        bi <= 1'b0;
    end
  end

  always_comb
  begin
    if (ier[2] && (oe || pe || fe || bi))
      iir_id = IRQ_LINE;
    else if (ier[0] && dr)
      iir_id = IRQ_RX_DATA;
    else if (ier[1] && !thr_full)
      iir_id = IRQ_THR_EMPTY;
    else
      iir_id = IRQ_NONE;
  end

  assign intr = (iir_id != IRQ_NONE);

  always_comb
  begin
    case (addr)
      RBR_THR_DLL: prdata = dlab ? dll : rbr;
      IER_DLM:     prdata = dlab ? dlm : {4'b0000, ier};
      IIR:         prdata = {5'b00000, iir_id};
      LCR:         prdata = lcr;
      MCR:         prdata = {3'b000, mcr};
      LSR:         prdata = lsr;
      MSR:         prdata = '0;   // No modem inputs
      default:     prdata = scr;
    endcase
  end

  // Break forces the line low; loopback parks sout at mark
  assign line_tx = txd && !line_cfg.set_break;
  assign sout    = loopback || line_tx;
  assign rxd_sel = loopback ? line_tx : sin;

endmodule

/* source/uart_pkg.sv */
// UART shared definitions
// Register offsets, LCR fields, state encodings and bus/event bundles

package uart_pkg;

  localparam int DATA_W = 8;   // Character path width
  localparam int DIV_W  = 16;  // Divisor latch width

  // Register offsets on the APB address
  typedef enum logic [2:0] {
    RBR_THR_DLL = 3'd0,
    IER_DLM     = 3'd1,
    IIR         = 3'd2,
    LCR         = 3'd3,
    MCR         = 3'd4,
    LSR         = 3'd5,
    MSR         = 3'd6,
    SCR         = 3'd7
  } reg_addr_e;

  typedef enum logic [1:0] {
    WL5 = 2'b00,
    WL6 = 2'b01,
    WL7 = 2'b10,
    WL8 = 2'b11
  } word_len_e;

  // IIR codes, bit 0 low means pending
  typedef enum logic [2:0] {
    IRQ_MODEM     = 3'd0,
    IRQ_NONE      = 3'd1,
    IRQ_THR_EMPTY = 3'd2,
    IRQ_RX_DATA   = 3'd4,
    IRQ_LINE      = 3'd6
  } irq_id_e;

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [2:0]        paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // Field order follows LCR bits 6:0
  typedef struct packed {
    logic      set_break;
    logic      stick_parity;
    logic      even_parity;
    logic      parity_en;
    logic      two_stop;
    word_len_e word_len;
  } line_cfg_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              done;
    logic              parity_err;
    logic              frame_err;
    logic              break_det;
  } rx_event_t;

endpackage
